//--- rtl/shift_decode.sv
`timescale 1ns/1ps
`include "shift_unit_params.svh"

module shift_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  shift_unit_pkg::shift_req_t in_req,
    output logic                       dec_valid,
    output shift_unit_pkg::exec_req_t  dec_req
);

    logic [`SHU_WIDTH-1:0] sel_onehot; // Bit k is set for an amount of k.

    // Binary to one-hot conversion of the shift amount.
    always_comb begin
        for (int k = 0; k < `SHU_WIDTH; k++) begin
            sel_onehot[k] = (in_req.amount == k);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // The request fields are only captured with a valid strobe.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_req.op   <= in_req.op;
            dec_req.data <= in_req.data;
            dec_req.sel  <= sel_onehot;
        end
    end

endmodule

//--- rtl/shift_execute.sv
`timescale 1ns/1ps
`include "shift_unit_params.svh"

module shift_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      dec_valid,
    input  shift_unit_pkg::exec_req_t dec_req,
    output logic                      exe_valid,
    output shift_unit_pkg::exec_res_t exe_res
);

    logic [`SHU_WIDTH-1:0] d;

    // One candidate word per distance for each operation.
    wire [`SHU_WIDTH-1:0][`SHU_WIDTH-1:0] shl_val;
    wire [`SHU_WIDTH-1:0][`SHU_WIDTH-1:0] shr_val;
    wire [`SHU_WIDTH-1:0][`SHU_WIDTH-1:0] rol_val;
    wire [`SHU_WIDTH-1:0][`SHU_WIDTH-1:0] ror_val;

    // Leftward moves lose bit WIDTH-k, rightward moves lose bit k-1.
    wire [`SHU_WIDTH-1:0] left_carry;
    wire [`SHU_WIDTH-1:0] right_carry;

    logic [`SHU_WIDTH-1:0][`SHU_WIDTH-1:0] fam_val;
    logic [`SHU_WIDTH-1:0]                 fam_carry;

    logic [`SHU_WIDTH-1:0] mux_val;
    logic                  mux_carry;

    assign d = dec_req.data;

    genvar k;
    generate
        for (k = 0; k < `SHU_WIDTH; k++) begin : g_dist
            if (k == 0) begin : g_pass
                // Distance zero passes the word through with no carry.
                assign shl_val[k]     = d;
                assign shr_val[k]     = d;
                assign rol_val[k]     = d;
                assign ror_val[k]     = d;
                assign left_carry[k]  = 1'b0;
                assign right_carry[k] = 1'b0;
            end else begin : g_slice
                assign shl_val[k] = {d[`SHU_WIDTH-1-k:0], {k{1'b0}}};
                assign shr_val[k] = {{k{1'b0}}, d[`SHU_WIDTH-1:k]};
                assign rol_val[k] = {d[`SHU_WIDTH-1-k:0], d[`SHU_WIDTH-1:`SHU_WIDTH-k]};
                assign ror_val[k] = {d[k-1:0], d[`SHU_WIDTH-1:k]};
                assign left_carry[k]  = d[`SHU_WIDTH-k]; // Also bit 0 of the ROL result.
                assign right_carry[k] = d[k-1];          // Also the top bit of the ROR result.
            end
        end
    endgenerate

    // The opcode picks one candidate family.
    always_comb begin
        fam_val   = shl_val;
        fam_carry = left_carry;
        case (dec_req.op)
            shift_unit_pkg::OP_SHL: begin
                fam_val   = shl_val;
                fam_carry = left_carry;
            end
            shift_unit_pkg::OP_SHR: begin
                fam_val   = shr_val;
                fam_carry = right_carry;
            end
            shift_unit_pkg::OP_ROL: begin
                fam_val   = rol_val;
                fam_carry = left_carry;
            end
            shift_unit_pkg::OP_ROR: begin
                fam_val   = ror_val;
                fam_carry = right_carry;
            end
            default: begin
                fam_val   = shl_val;
                fam_carry = left_carry;
            end
        endcase
    end

    // AND-OR mux over the one-hot distance select.
    always_comb begin
        mux_val   = '0;
        mux_carry = 1'b0;
        for (int i = 0; i < `SHU_WIDTH; i++) begin
            mux_val   = mux_val | (fam_val[i] & {`SHU_WIDTH{dec_req.sel[i]}});
            mux_carry = mux_carry | (fam_carry[i] & dec_req.sel[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_res.value <= mux_val;
            exe_res.carry <= mux_carry;
        end
    end

endmodule

//--- rtl/shift_result.sv
`timescale 1ns/1ps

module shift_result (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       exe_valid,
    input  shift_unit_pkg::exec_res_t  exe_res,
    output logic                       out_valid,
    output shift_unit_pkg::shift_rsp_t out_rsp
);

    logic zero;

    assign zero = ~|exe_res.value; // Set only when every result bit is clear.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= exe_valid;
        end
    end

    // Final response register, loaded with the execute strobe.
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            out_rsp.value <= exe_res.value;
            out_rsp.carry <= exe_res.carry;
            out_rsp.zero  <= zero;
        end
    end

endmodule

//--- rtl/shift_unit_params.svh
`ifndef SHIFT_UNIT_PARAMS_SVH
`define SHIFT_UNIT_PARAMS_SVH

// Data word width of the shift unit. 16 and 32 work as well.
`define SHU_WIDTH 8

// Width of the binary shift amount.
`define SHU_AMT_BITS ($clog2(`SHU_WIDTH))

`endif

//--- rtl/shift_unit_pkg.sv
`include "shift_unit_params.svh"

package shift_unit_pkg;

    typedef enum logic [1:0] {
        OP_SHL = 2'b00, // Logical shift left.
        OP_SHR = 2'b01, // Logical shift right.
        OP_ROL = 2'b10,
        OP_ROR = 2'b11
    } shift_op_e;

    // Request as it enters the unit.
    typedef struct packed {
        shift_op_e                 op;
        logic [`SHU_WIDTH-1:0]     data;
        logic [`SHU_AMT_BITS-1:0]  amount;
    } shift_req_t;

    // Decoded request. Bit k of sel selects a shift distance of k.
    typedef struct packed {
        shift_op_e              op;
        logic [`SHU_WIDTH-1:0]  data;
        logic [`SHU_WIDTH-1:0]  sel;
    } exec_req_t;

    typedef struct packed {
        logic [`SHU_WIDTH-1:0]  value;
        logic                   carry;
    } exec_res_t;

    // Response as it leaves the unit.
    typedef struct packed {
        logic [`SHU_WIDTH-1:0]  value;
        logic                   carry;
        logic                   zero;
    } shift_rsp_t;

endpackage

//--- rtl/shift_unit_top.sv
`timescale 1ns/1ps

module shift_unit_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  shift_unit_pkg::shift_req_t in_req,
    output logic                       out_valid,
    output shift_unit_pkg::shift_rsp_t out_rsp
);

    logic                      dec_valid;
    shift_unit_pkg::exec_req_t dec_req;   // Opcode, data and one-hot distance.
    logic                      exe_valid;
    shift_unit_pkg::exec_res_t exe_res;

    // Three register stages, so a response follows its request by three cycles.
    shift_decode i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .dec_valid (dec_valid),
        .dec_req   (dec_req)
    );

    shift_execute i_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_req   (dec_req),
        .exe_valid (exe_valid),
        .exe_res   (exe_res)
    );

    shift_result i_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe_res   (exe_res),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

//--- sources.f
+incdir+rtl
rtl/shift_unit_pkg.sv
rtl/shift_decode.sv
rtl/shift_execute.sv
rtl/shift_result.sv
rtl/shift_unit_top.sv
verification/shift_unit_asserts.sv
verification/tb_shift_unit.sv

//--- verification/shift_unit_asserts.sv
`timescale 1ns/1ps

module shift_unit_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid,
    input logic                      dec_valid,
    input shift_unit_pkg::exec_req_t dec_req,
    input logic                      out_valid
);

    int fail_cnt = 0; // Number of assertion failures so far.

    // Exactly one distance may be selected in the AND-OR mux.
    sel_onehot_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> $onehot(dec_req.sel)
    ) else begin
        fail_cnt++;
        $error("Decode select is not one-hot while dec_valid is high");
    end

    // Fixed latency of three register stages.
    resp_latency_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> ##3 out_valid
    ) else begin
        fail_cnt++;
        $error("No out_valid three cycles after an in_valid");
    end

    no_spurious_resp_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 3)
    ) else begin
        fail_cnt++;
        $error("out_valid without an in_valid three cycles earlier");
    end

endmodule

bind shift_unit_top shift_unit_asserts i_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .dec_valid (dec_valid),
    .dec_req   (dec_req),
    .out_valid (out_valid)
);

//--- verification/tb_shift_unit.sv
`timescale 1ns/1ps
`include "shift_unit_params.svh"

module tb_shift_unit;

    localparam int CLK_PERIOD  = 8;
    localparam int RESET_TICKS = 5;
    localparam int TAB_N       = 32;
    localparam int NUM_RANDOM  = 32;
    localparam int NUM_TESTS   = TAB_N + NUM_RANDOM;
    localparam int WATCHDOG_NS = (NUM_TESTS + 3 + 10) * CLK_PERIOD + RESET_TICKS * CLK_PERIOD;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    shift_unit_pkg::shift_req_t in_req;
    logic                       out_valid;
    shift_unit_pkg::shift_rsp_t out_rsp;

    // Directed table, one entry per request.
    string                      tab_name  [TAB_N];
    shift_unit_pkg::shift_op_e  tab_op    [TAB_N];
    logic [`SHU_WIDTH-1:0]      tab_data  [TAB_N];
    logic [`SHU_AMT_BITS-1:0]   tab_amt   [TAB_N];
    logic [`SHU_WIDTH-1:0]      tab_val   [TAB_N];
    logic                       tab_carry [TAB_N];
    logic                       tab_zero  [TAB_N];
    int                         tab_fill = 0;

    // Responses still expected, oldest first.
    string                      exp_name_q  [$];
    logic [`SHU_WIDTH-1:0]      exp_val_q   [$];
    logic                       exp_carry_q [$];
    logic                       exp_zero_q  [$];
    int                         exp_cycle_q [$];

    int     cycle_cnt = 0;
    int     done_cnt  = 0;
    int     fail_cnt  = 0;
    int     err_cnt   = 0;
    integer seed      = 32'ha7d5_5b09;

    shift_unit_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic add_entry(input string name, input shift_unit_pkg::shift_op_e op,
                             input logic [`SHU_WIDTH-1:0] data, input int amt,
                             input logic [`SHU_WIDTH-1:0] val,
                             input logic carry, input logic zero);
        tab_name[tab_fill]  = name;
        tab_op[tab_fill]    = op;
        tab_data[tab_fill]  = data;
        tab_amt[tab_fill]   = amt;
        tab_val[tab_fill]   = val;
        tab_carry[tab_fill] = carry;
        tab_zero[tab_fill]  = zero;
        tab_fill++;
    endtask

    task automatic load_table();
        add_entry("shl_b5_1", shift_unit_pkg::OP_SHL, 8'hb5, 1, 8'h6a, 1'b1, 1'b0);
        add_entry("shl_b5_2", shift_unit_pkg::OP_SHL, 8'hb5, 2, 8'hd4, 1'b0, 1'b0);
        add_entry("shl_b5_3", shift_unit_pkg::OP_SHL, 8'hb5, 3, 8'ha8, 1'b1, 1'b0);
        add_entry("shl_1f_4", shift_unit_pkg::OP_SHL, 8'h1f, 4, 8'hf0, 1'b1, 1'b0);
        add_entry("shl_b5_5", shift_unit_pkg::OP_SHL, 8'hb5, 5, 8'ha0, 1'b0, 1'b0);
        add_entry("shl_b5_6", shift_unit_pkg::OP_SHL, 8'hb5, 6, 8'h40, 1'b1, 1'b0);
        add_entry("shl_b5_7", shift_unit_pkg::OP_SHL, 8'hb5, 7, 8'h80, 1'b0, 1'b0);
        add_entry("shl_80_1", shift_unit_pkg::OP_SHL, 8'h80, 1, 8'h00, 1'b1, 1'b1);
        add_entry("shr_b5_1", shift_unit_pkg::OP_SHR, 8'hb5, 1, 8'h5a, 1'b1, 1'b0);
        add_entry("shr_b5_2", shift_unit_pkg::OP_SHR, 8'hb5, 2, 8'h2d, 1'b0, 1'b0);
        add_entry("shr_b5_3", shift_unit_pkg::OP_SHR, 8'hb5, 3, 8'h16, 1'b1, 1'b0);
        add_entry("shr_b5_4", shift_unit_pkg::OP_SHR, 8'hb5, 4, 8'h0b, 1'b0, 1'b0);
        add_entry("shr_b5_5", shift_unit_pkg::OP_SHR, 8'hb5, 5, 8'h05, 1'b1, 1'b0);
        add_entry("shr_b5_6", shift_unit_pkg::OP_SHR, 8'hb5, 6, 8'h02, 1'b1, 1'b0);
        add_entry("shr_b5_7", shift_unit_pkg::OP_SHR, 8'hb5, 7, 8'h01, 1'b0, 1'b0);
        add_entry("shr_01_1", shift_unit_pkg::OP_SHR, 8'h01, 1, 8'h00, 1'b1, 1'b1);
        add_entry("rol_b5_1", shift_unit_pkg::OP_ROL, 8'hb5, 1, 8'h6b, 1'b1, 1'b0);
        add_entry("rol_b5_3", shift_unit_pkg::OP_ROL, 8'hb5, 3, 8'had, 1'b1, 1'b0);
        add_entry("rol_81_4", shift_unit_pkg::OP_ROL, 8'h81, 4, 8'h18, 1'b0, 1'b0);
        add_entry("rol_b5_7", shift_unit_pkg::OP_ROL, 8'hb5, 7, 8'hda, 1'b0, 1'b0);
        add_entry("ror_b5_1", shift_unit_pkg::OP_ROR, 8'hb5, 1, 8'hda, 1'b1, 1'b0);
        add_entry("ror_b5_3", shift_unit_pkg::OP_ROR, 8'hb5, 3, 8'hb6, 1'b1, 1'b0);
        add_entry("ror_81_4", shift_unit_pkg::OP_ROR, 8'h81, 4, 8'h18, 1'b0, 1'b0);
        add_entry("ror_b5_6", shift_unit_pkg::OP_ROR, 8'hb5, 6, 8'hd6, 1'b1, 1'b0);
        add_entry("shl_b5_0", shift_unit_pkg::OP_SHL, 8'hb5, 0, 8'hb5, 1'b0, 1'b0);
        add_entry("shr_b5_0", shift_unit_pkg::OP_SHR, 8'hb5, 0, 8'hb5, 1'b0, 1'b0);
        add_entry("rol_b5_0", shift_unit_pkg::OP_ROL, 8'hb5, 0, 8'hb5, 1'b0, 1'b0);
        add_entry("ror_b5_0", shift_unit_pkg::OP_ROR, 8'hb5, 0, 8'hb5, 1'b0, 1'b0);
        add_entry("rol_00_3", shift_unit_pkg::OP_ROL, 8'h00, 3, 8'h00, 1'b0, 1'b1);
        add_entry("ror_00_5", shift_unit_pkg::OP_ROR, 8'h00, 5, 8'h00, 1'b0, 1'b1);
        add_entry("shl_00_0", shift_unit_pkg::OP_SHL, 8'h00, 0, 8'h00, 1'b0, 1'b1);
        add_entry("rol_ff_2", shift_unit_pkg::OP_ROL, 8'hff, 2, 8'hff, 1'b1, 1'b0);
    endtask

    // Reference model for the random requests.
    task automatic compute_expected(input shift_unit_pkg::shift_op_e op,
                                    input logic [`SHU_WIDTH-1:0] d,
                                    input logic [`SHU_AMT_BITS-1:0] n,
                                    output logic [`SHU_WIDTH-1:0] v,
                                    output logic c, output logic z);
        int amt;
        amt = n;
        v   = d;
        c   = 1'b0;
        if (amt != 0) begin
            case (op)
                shift_unit_pkg::OP_SHL: begin
                    v = d << amt;
                    c = d[`SHU_WIDTH - amt]; // Last bit pushed out at the top.
                end
                shift_unit_pkg::OP_SHR: begin
                    v = d >> amt;
                    c = d[amt - 1];
                end
                shift_unit_pkg::OP_ROL: begin
                    v = (d << amt) | (d >> (`SHU_WIDTH - amt));
                    c = v[0];
                end
                default: begin
                    v = (d >> amt) | (d << (`SHU_WIDTH - amt));
                    c = v[`SHU_WIDTH-1];
                end
            endcase
        end
        z = (v == '0);
    endtask

    // Called on a falling edge. The request is sampled on the next rising edge.
    task automatic send_request(input string name, input shift_unit_pkg::shift_op_e op,
                                input logic [`SHU_WIDTH-1:0] data,
                                input logic [`SHU_AMT_BITS-1:0] amt,
                                input logic [`SHU_WIDTH-1:0] val, input logic carry,
                                input logic zero);
        in_valid      = 1'b1;
        in_req.op     = op;
        in_req.data   = data;
        in_req.amount = amt;
        exp_name_q.push_back(name);
        exp_val_q.push_back(val);
        exp_carry_q.push_back(carry);
        exp_zero_q.push_back(zero);
        exp_cycle_q.push_back(cycle_cnt);
    endtask

    always @(posedge clk) begin
        string                 nm;
        logic [`SHU_WIDTH-1:0] ev;
        logic                  ec;
        logic                  ez;
        int                    ecyc;
        if (out_valid) begin
            if (exp_val_q.size() == 0) begin
                $display("Error: out_valid was high while no request was outstanding");
                err_cnt++;
            end else begin
                nm   = exp_name_q.pop_front();
                ev   = exp_val_q.pop_front();
                ec   = exp_carry_q.pop_front();
                ez   = exp_zero_q.pop_front();
                ecyc = exp_cycle_q.pop_front();
                done_cnt++;
                if (out_rsp.value !== ev || out_rsp.carry !== ec || out_rsp.zero !== ez) begin
                    $display("Fail %s: expected value=%h carry=%b zero=%b, %s",
                             nm, ev, ec, ez,
                             $sformatf("actual value=%h carry=%b zero=%b",
                                       out_rsp.value, out_rsp.carry, out_rsp.zero));
                    fail_cnt++;
                end else if (cycle_cnt != ecyc + 3) begin
                    $display("Fail %s: expected response in cycle %0d, actual cycle %0d",
                             nm, ecyc + 3, cycle_cnt);
                    fail_cnt++;
                end else begin
                    $display("Ok   %s: value=%h carry=%b zero=%b",
                             nm, out_rsp.value, out_rsp.carry, out_rsp.zero);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired with %0d responses outstanding", exp_val_q.size());
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0]                r;
        shift_unit_pkg::shift_op_e  op;
        logic [`SHU_WIDTH-1:0]      data;
        logic [`SHU_AMT_BITS-1:0]   amt;
        logic [`SHU_WIDTH-1:0]      ev;
        logic                       ec;
        logic                       ez;
        int                         drain;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        load_table();
        repeat (RESET_TICKS) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Table and random requests go out back to back.
        for (int i = 0; i < TAB_N; i++) begin
            @(negedge clk);
            send_request(tab_name[i], tab_op[i], tab_data[i], tab_amt[i],
                         tab_val[i], tab_carry[i], tab_zero[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r    = $random(seed);
            op   = shift_unit_pkg::shift_op_e'(r[1:0]);
            r    = $random(seed);
            data = r[`SHU_WIDTH-1:0];
            r    = $random(seed);
            amt  = r[`SHU_AMT_BITS-1:0];
            compute_expected(op, data, amt, ev, ec, ez);
            @(negedge clk);
            send_request($sformatf("rand_%0d", i), op, data, amt, ev, ec, ez);
        end
        @(negedge clk);
        in_valid = 1'b0;
        drain    = 0;
        while (exp_val_q.size() != 0 && drain < 10) begin
            @(negedge clk);
            drain++;
        end
        if (exp_val_q.size() != 0) begin
            $display("Error: %0d responses never arrived", exp_val_q.size());
            err_cnt++;
        end
        $display("Tests: %0d run, %0d checked, %0d failed, %0d errors, %0d assertion failures",
                 NUM_TESTS, done_cnt, fail_cnt, err_cnt, i_dut.i_asserts.fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && done_cnt == NUM_TESTS &&
            i_dut.i_asserts.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
